//--- Makefile
TOP = cpuTb
LOG = sim.log

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

obj_dir/V$(TOP): compile.f hw/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

//--- compile.f
hw/cpuPkg.sv
hw/ctrlIf.sv
hw/regFile.sv
hw/alu.sv
hw/cpuFsm.sv
hw/datapath.sv
hw/cpuTop.sv
tb/cpuAsserts.sv
tb/cpuTb.sv

//--- hw/alu.sv
`timescale 1ns/10ps
`default_nettype none
// =====================================
// Operand b is the destination, a the source
// Flags not named by a function come out as zero
// =====================================

module alu (
	input logic [3:0] func,
	input logic [cpuPkg::dataWidth-1:0] a,
	input logic [cpuPkg::dataWidth-1:0] b,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic [cpuPkg::flagWidth-1:0] flagsNext
);

	localparam int msb = cpuPkg::dataWidth - 1;

	// One extra bit keeps the carry and the borrow
	logic [cpuPkg::dataWidth:0] addFull;
	logic [cpuPkg::dataWidth:0] subFull;

	assign addFull = {1'b0, b} + {1'b0, a};
	assign subFull = {1'b0, b} - {1'b0, a};

	always_comb begin
		result = b;
		flagsNext = '0;
		case (func)
			cpuPkg::funcAdd: begin
				result = addFull[msb:0];
				flagsNext[cpuPkg::flagC] = addFull[cpuPkg::dataWidth];
				// Overflow when both inputs share a sign and the sum does not
				flagsNext[cpuPkg::flagF] = (a[msb] == b[msb]) && (addFull[msb] != b[msb]);
				flagsNext[cpuPkg::flagZ] = (addFull[msb:0] == '0);
				flagsNext[cpuPkg::flagN] = addFull[msb];
			end
			cpuPkg::funcSub: begin
				result = subFull[msb:0];
				// Carry here means a borrow out of the top bit
				flagsNext[cpuPkg::flagC] = subFull[cpuPkg::dataWidth];
				flagsNext[cpuPkg::flagF] = (a[msb] != b[msb]) && (subFull[msb] != b[msb]);
				flagsNext[cpuPkg::flagZ] = (subFull[msb:0] == '0);
				flagsNext[cpuPkg::flagN] = subFull[msb];
			end
			cpuPkg::funcCmp: begin
				// The borrow of b minus a is exactly the unsigned lower test
				flagsNext[cpuPkg::flagL] = subFull[cpuPkg::dataWidth];
				flagsNext[cpuPkg::flagZ] = (b == a);
			end
			cpuPkg::funcAnd: result = b & a;
			cpuPkg::funcOr: result = b | a;
			cpuPkg::funcXor: result = b ^ a;
			// MOVI also arrives here with the immediate in place of a
			cpuPkg::funcMov: result = a;
			default: result = b;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/cpuFsm.sv
`timescale 1ns/10ps
`default_nettype none
// =====================================
// Memory must answer one cycle after the address
// Unknown opcodes fall through stExecR as no-ops
// =====================================

module cpuFsm (
	input logic clk,
	input logic rst,
	ctrlIf.ctrl ctrl
);

	cpuPkg::stateT state;
	cpuPkg::stateT nextState;

	logic [3:0] opcode;
	logic [3:0] func;
	logic [3:0] cond;
	logic branchTaken;
	logic writesReg;
	logic writesFlags;

	// Instruction fields as seen by the FSM
	// In stDecode this is the raw read data, later it is the IR
	assign opcode = ctrl.instr[15:12];
	assign func = ctrl.instr[7:4];
	assign cond = ctrl.instr[11:8];

	// EQ needs Z, GT needs Z clear and L set, UN always branches
	always_comb begin
		case (cond)
			cpuPkg::condEq: branchTaken = ctrl.flags[cpuPkg::flagZ];
			cpuPkg::condGt: branchTaken = !ctrl.flags[cpuPkg::flagZ] && ctrl.flags[cpuPkg::flagL];
			cpuPkg::condUn: branchTaken = 1'b1;
			default: branchTaken = 1'b0;
		endcase
	end

	// CMP and branches that fall through must not touch the register file
	assign writesReg = (opcode == cpuPkg::opMovi) ||
		(opcode == cpuPkg::opRType && func != cpuPkg::funcCmp);

	// Only arithmetic and compare change the flags
	assign writesFlags = (opcode == cpuPkg::opRType) && (func == cpuPkg::funcAdd ||
		func == cpuPkg::funcSub || func == cpuPkg::funcCmp);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cpuPkg::stStartup;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			cpuPkg::stStartup: nextState = cpuPkg::stFetch;
			cpuPkg::stFetch: nextState = cpuPkg::stDecode;
			cpuPkg::stLoadAddr: nextState = cpuPkg::stLoadWb;
			cpuPkg::stDecode: begin
				if (opcode == cpuPkg::opMem && func == cpuPkg::funcLoad) begin
					nextState = cpuPkg::stLoadAddr;
				end else if (opcode == cpuPkg::opMem && func == cpuPkg::funcStor) begin
					nextState = cpuPkg::stStore;
				end else if (opcode == cpuPkg::opBranch && branchTaken) begin
					nextState = cpuPkg::stBranch;
				end else begin
					// A branch not taken also lands here and just advances the PC
					nextState = cpuPkg::stExecR;
				end
			end
			default: nextState = cpuPkg::stFetch;
		endcase
	end

	// Every strobe gets a value in every state so none is ever unknown
	always_comb begin
		ctrl.pcEnable = 1'b0;
		ctrl.regWe = 1'b0;
		ctrl.addrSel = 1'b0;
		ctrl.wbSel = 1'b0;
		ctrl.memWe = 1'b0;
		ctrl.irLoad = 1'b0;
		ctrl.pcBranch = 1'b0;
		ctrl.flagWe = 1'b0;
		ctrl.regClear = 1'b0;
		case (state)
			cpuPkg::stStartup: ctrl.regClear = 1'b1;
			// The read data is valid now and is captured into the IR
			cpuPkg::stDecode: ctrl.irLoad = 1'b1;
			cpuPkg::stExecR: begin
				ctrl.pcEnable = 1'b1;
				ctrl.regWe = writesReg;
				ctrl.flagWe = writesFlags;
			end
			cpuPkg::stStore: begin
				ctrl.pcEnable = 1'b1;
				ctrl.addrSel = 1'b1;
				ctrl.memWe = 1'b1;
			end
			// Address register goes out first and the data returns in stLoadWb
			cpuPkg::stLoadAddr: ctrl.addrSel = 1'b1;
			cpuPkg::stLoadWb: begin
				ctrl.pcEnable = 1'b1;
				ctrl.addrSel = 1'b1;
				ctrl.regWe = 1'b1;
				ctrl.wbSel = 1'b1;
			end
			cpuPkg::stBranch: begin
				ctrl.pcEnable = 1'b1;
				ctrl.pcBranch = 1'b1;
			end
			default: ctrl.pcEnable = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/cpuPkg.sv
`default_nettype none
// =====================================
// Word and address are both 16 bits wide
// Encodings follow the CR16-style subset only
// =====================================

package cpuPkg;

	// Word, address and register index widths
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 4;
	localparam int flagWidth = 5;

	typedef logic [dataWidth-1:0] wordT;

	// Opcodes live in instruction bits 15 to 12
	localparam logic [3:0] opRType = 4'b0000;
	localparam logic [3:0] opMem = 4'b0100;
	localparam logic [3:0] opMovi = 4'b1101;
	localparam logic [3:0] opBranch = 4'b1100;

	// Function codes live in bits 7 to 4
	localparam logic [3:0] funcAnd = 4'b0001;
	localparam logic [3:0] funcOr = 4'b0010;
	localparam logic [3:0] funcXor = 4'b0011;
	localparam logic [3:0] funcAdd = 4'b0101;
	localparam logic [3:0] funcSub = 4'b1001;
	localparam logic [3:0] funcCmp = 4'b1011;
	localparam logic [3:0] funcMov = 4'b1101;
	// Memory function codes only mean something together with opMem
	localparam logic [3:0] funcLoad = 4'b0000;
	localparam logic [3:0] funcStor = 4'b0100;

	// Branch conditions live in bits 11 to 8
	localparam logic [3:0] condEq = 4'b0000;
	localparam logic [3:0] condGt = 4'b1100;
	localparam logic [3:0] condUn = 4'b1110;

	// Bit positions inside the flag word
	localparam int flagC = 0;
	localparam int flagL = 1;
	localparam int flagF = 2;
	localparam int flagZ = 3;
	localparam int flagN = 4;

	// Control states, numbered like S0 to S6 plus the startup state
	typedef enum logic [3:0] {
		stFetch = 4'd0,
		stDecode = 4'd1,
		stExecR = 4'd2,
		stStore = 4'd3,
		stLoadAddr = 4'd4,
		stLoadWb = 4'd5,
		stBranch = 4'd6,
		stStartup = 4'd7
	} stateT;

endpackage

`default_nettype wire

//--- hw/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none
// =====================================
// One shared port for code and data
// The RAM must register its read data
// =====================================

module cpuTop (
	input logic clk,
	input logic rst,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memWrData,
	output logic memWe,
	input logic [cpuPkg::dataWidth-1:0] memRdData
);

	ctrlIf ctrlBus ();

	cpuFsm uFsm (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrlBus.ctrl)
	);

	datapath uDp (
		.clk(clk),
		.rst(rst),
		.dp(ctrlBus.dp),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memRdData(memRdData)
	);

	// The write strobe goes straight from the FSM to the pin
	assign memWe = ctrlBus.memWe;

endmodule

`default_nettype wire

//--- hw/ctrlIf.sv
`timescale 1ns/10ps
`default_nettype none
// =====================================
// Strobes are plain levels with no handshake
// =====================================

interface ctrlIf;

	// Strobes from the FSM
	logic pcEnable;
	logic regWe;
	// High selects the register in bits 3 to 0 as memory address, low selects the PC
	logic addrSel;
	// High writes back memory read data, low writes back the ALU result
	logic wbSel;
	logic memWe;
	logic irLoad;
	logic pcBranch;
	logic flagWe;
	logic regClear;

	// Status returned by the datapath
	logic [cpuPkg::dataWidth-1:0] instr;
	logic [cpuPkg::flagWidth-1:0] flags;

	modport ctrl (
		output pcEnable, regWe, addrSel, wbSel, memWe, irLoad, pcBranch, flagWe, regClear,
		input instr, flags
	);

	modport dp (
		input pcEnable, regWe, addrSel, wbSel, memWe, irLoad, pcBranch, flagWe, regClear,
		output instr, flags
	);

endinterface

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/10ps
`default_nettype none
// =====================================
// The PC points at the current instruction until it retires
// =====================================

module datapath (
	input logic clk,
	input logic rst,
	ctrlIf.dp dp,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memWrData,
	input logic [cpuPkg::dataWidth-1:0] memRdData
);

	cpuPkg::wordT pc;
	cpuPkg::wordT ir;
	cpuPkg::wordT rDataA;
	cpuPkg::wordT rDataB;
	cpuPkg::wordT aluA;
	cpuPkg::wordT aluResult;
	cpuPkg::wordT wbData;
	cpuPkg::wordT branchTarget;
	logic [3:0] aluFunc;
	logic isMovi;
	logic [cpuPkg::flagWidth-1:0] flagReg;
	logic [cpuPkg::flagWidth-1:0] flagsNext;
	logic [cpuPkg::flagWidth-1:0] flagMask;

	// Bits 11 to 8 name the destination or store data, bits 3 to 0 the source or address
	regFile uRegs (
		.clk(clk),
		.rst(rst),
		.clear(dp.regClear),
		.we(dp.regWe),
		.wAddr(ir[11:8]),
		.rAddrA(ir[11:8]),
		.rAddrB(ir[3:0]),
		.wData(wbData),
		.rDataA(rDataA),
		.rDataB(rDataB)
	);

	// MOVI reuses the MOV path with a zero-extended immediate
	assign isMovi = (ir[15:12] == cpuPkg::opMovi);
	assign aluFunc = isMovi ? cpuPkg::funcMov : ir[7:4];
	assign aluA = isMovi ? {{(cpuPkg::dataWidth-8){1'b0}}, ir[7:0]} : rDataB;

	alu uAlu (
		.func(aluFunc),
		.a(aluA),
		.b(rDataA),
		.result(aluResult),
		.flagsNext(flagsNext)
	);

	assign wbData = dp.wbSel ? memRdData : aluResult;
	assign memAddr = dp.addrSel ? rDataB : pc;
	assign memWrData = rDataA;

	// The FSM decodes straight from memory during stDecode
	assign dp.instr = dp.irLoad ? memRdData : ir;
	assign dp.flags = flagReg;

	// Displacement is relative to the branch itself
	assign branchTarget = pc + {{(cpuPkg::dataWidth-8){ir[7]}}, ir[7:0]};

	always_ff @(posedge clk) begin
		if (rst || dp.regClear) begin
			pc <= '0;
		end else if (dp.pcEnable) begin
			pc <= dp.pcBranch ? branchTarget : pc + cpuPkg::wordT'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (dp.irLoad) begin
			ir <= memRdData;
		end
	end

	// CMP touches only L and Z, ADD and SUB only C, F, Z and N
	always_comb begin
		flagMask = '0;
		if (aluFunc == cpuPkg::funcCmp) begin
			flagMask[cpuPkg::flagL] = 1'b1;
			flagMask[cpuPkg::flagZ] = 1'b1;
		end else begin
			flagMask[cpuPkg::flagC] = 1'b1;
			flagMask[cpuPkg::flagF] = 1'b1;
			flagMask[cpuPkg::flagZ] = 1'b1;
			flagMask[cpuPkg::flagN] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flagReg <= '0;
		end else if (dp.flagWe) begin
			flagReg <= (flagReg & ~flagMask) | (flagsNext & flagMask);
		end
	end

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/10ps
`default_nettype none
// =====================================
// Reads are combinational, so a write shows up the next cycle
// =====================================

module regFile (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic we,
	input logic [cpuPkg::regAddrWidth-1:0] wAddr,
	input logic [cpuPkg::regAddrWidth-1:0] rAddrA,
	input logic [cpuPkg::regAddrWidth-1:0] rAddrB,
	input logic [cpuPkg::dataWidth-1:0] wData,
	output logic [cpuPkg::dataWidth-1:0] rDataA,
	output logic [cpuPkg::dataWidth-1:0] rDataB
);

	// One word per register index
	cpuPkg::wordT regs [2**cpuPkg::regAddrWidth];

	// The FSM pulses clear once in stStartup so software starts from all zeros
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			for (int i = 0; i < 2**cpuPkg::regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wAddr] <= wData;
		end
	end

	// Port A reads the destination or store data register
	assign rDataA = regs[rAddrA];
	// Port B reads the source or address register
	assign rDataB = regs[rAddrB];

endmodule

`default_nettype wire

//--- tb/cpuAsserts.sv
`timescale 1ns/10ps
`default_nettype none
// ========================================
// Bound into cpuFsm and sees its state register and strobes
// Checks assume the program never raises rst again mid-run
// ========================================

module cpuAsserts (
	input logic clk,
	input logic rst,
	input cpuPkg::stateT state,
	input logic memWe,
	input logic regWe,
	input logic pcEnable,
	input logic irLoad,
	input logic flagWe
);

	// Each group of checks keeps its own failure count
	int weFails = 0;
	int seqFails = 0;
	int rstFails = 0;
	int failCount;

	assign failCount = weFails + seqFails + rstFails;

	// A memory write only comes from stStore
	weInStore: assert property (@(posedge clk) !rst && memWe |-> state == cpuPkg::stStore)
		else begin
			$error("memWe high outside stStore");
			weFails++;
		end

	// Every STOR gives exactly one write cycle
	weSingle: assert property (@(posedge clk) !rst && memWe |=> !memWe)
		else begin
			$error("memWe high for two cycles in a row");
			weFails++;
		end

	startupNext: assert property (@(posedge clk)
		!rst && state == cpuPkg::stStartup |=> state == cpuPkg::stFetch)
		else begin
			$error("stStartup not followed by stFetch");
			seqFails++;
		end

	// Execute states retire the instruction and go back to fetch
	retireNext: assert property (@(posedge clk)
		!rst && state inside {cpuPkg::stExecR, cpuPkg::stStore, cpuPkg::stLoadWb,
			cpuPkg::stBranch} |=> state == cpuPkg::stFetch)
		else begin
			$error("execute state not followed by stFetch");
			seqFails++;
		end

	decodeNext: assert property (@(posedge clk)
		!rst && state == cpuPkg::stDecode |=> state inside {cpuPkg::stExecR,
			cpuPkg::stStore, cpuPkg::stLoadAddr, cpuPkg::stBranch})
		else begin
			$error("stDecode not followed by an execute state");
			seqFails++;
		end

	// regClear is left out because reset holds the FSM in stStartup where it is high
	quietInReset: assert property (@(posedge clk)
		rst |-> !(memWe || regWe || pcEnable || irLoad || flagWe))
		else begin
			$error("strobe high while rst is asserted");
			rstFails++;
		end

endmodule

`default_nettype wire

//--- tb/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none
// ========================================
// RAM model decodes only the low 8 address bits, 256 words
// Program sits at 0, operands at 0x80, results from 0xa0 up
// ========================================

module cpuTb;

	localparam int ramWords = 256;
	// A fetch address held this many cycles means the halt loop was reached
	localparam int haltLimit = 8;
	localparam int maxCycles = 3000;
	localparam cpuPkg::wordT marker = 16'h0011;
	localparam cpuPkg::wordT poison = 16'h00ee;

	logic clk;
	logic rst;
	cpuPkg::wordT memAddr;
	cpuPkg::wordT memWrData;
	logic memWe;
	cpuPkg::wordT memRdData;

	cpuPkg::wordT ram [ramWords];
	int seed;
	int errors;
	int timeouts;
	logic [7:0] progPtr;
	cpuPkg::wordT d0;
	cpuPkg::wordT d1;
	cpuPkg::wordT d2;
	logic [7:0] immA;
	cpuPkg::wordT haltPc;
	// Expected RAM contents, one entry per checked word
	string expName [$];
	logic [7:0] expAddr [$];
	cpuPkg::wordT expVal [$];

	cpuTop dut0 (
		.clk(clk),
		.rst(rst),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWe(memWe),
		.memRdData(memRdData)
	);

	bind cpuFsm cpuAsserts fsmChecks (
		.clk(clk),
		.rst(rst),
		.state(state),
		.memWe(ctrl.memWe),
		.regWe(ctrl.regWe),
		.pcEnable(ctrl.pcEnable),
		.irLoad(ctrl.irLoad),
		.flagWe(ctrl.flagWe)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Synchronous RAM, read data shows up one cycle after the address
	always @(posedge clk) begin
		if (memWe) begin
			ram[memAddr[7:0]] <= memWrData;
		end
		memRdData <= ram[memAddr[7:0]];
	end

	// Instruction encoders, one per instruction format
	function automatic cpuPkg::wordT rType(logic [3:0] func, logic [3:0] dst, logic [3:0] src);
		return {cpuPkg::opRType, dst, func, src};
	endfunction

	function automatic cpuPkg::wordT movi(logic [3:0] dst, logic [7:0] imm);
		return {cpuPkg::opMovi, dst, imm};
	endfunction

	function automatic cpuPkg::wordT memOp(logic [3:0] func, logic [3:0] rg, logic [3:0] addrReg);
		return {cpuPkg::opMem, rg, func, addrReg};
	endfunction

	function automatic cpuPkg::wordT branchOp(logic [3:0] cond, logic [7:0] disp);
		return {cpuPkg::opBranch, cond, disp};
	endfunction

	// Untouched words keep this, so a skipped store is visible
	function automatic cpuPkg::wordT fillWord(logic [7:0] addr);
		return {addr ^ 8'h5a, addr};
	endfunction

	task automatic emit(cpuPkg::wordT word);
		ram[progPtr] = word;
		progPtr = progPtr + 8'd1;
	endtask

	// r15 always carries the store address
	task automatic storeAt(logic [3:0] rg, logic [7:0] addr);
		emit(movi(4'd15, addr));
		emit(memOp(cpuPkg::funcStor, rg, 4'd15));
	endtask

	task automatic expectWord(string name, logic [7:0] addr, cpuPkg::wordT value);
		expName.push_back(name);
		expAddr.push_back(addr);
		expVal.push_back(value);
	endtask

	// r4 starts as d0 and is combined with d1 in r2
	task automatic aluCase(string name, logic [3:0] func, logic [7:0] addr, cpuPkg::wordT value);
		emit(rType(cpuPkg::funcMov, 4'd4, 4'd1));
		emit(rType(func, 4'd4, 4'd2));
		storeAt(4'd4, addr);
		expectWord(name, addr, value);
	endtask

	// Branch forward by 3 over a two-word store
	task automatic branchOver(logic [3:0] cond, logic [3:0] rg, logic [7:0] addr);
		emit(branchOp(cond, 8'd3));
		storeAt(rg, addr);
	endtask

	initial begin
		int cycles;
		int steady;
		int assertFails;
		cpuPkg::wordT lastAddr;
		seed = 32'h9bc80af2;
		errors = 0;
		timeouts = 0;
		rst = 1'b1;
		memRdData = '0;
		for (int i = 0; i < ramWords; i++) begin
			ram[8'(i)] = fillWord(8'(i));
		end
		d0 = 16'($random(seed));
		d1 = 16'($random(seed));
		d2 = 16'($random(seed));
		immA = 8'($random(seed));
		// The BEQ fall-through case needs two different operands
		if (d1 == d0) begin
			d1 = d1 ^ 16'h0001;
		end
		// A set top bit shows that MOVI zero-extends its immediate
		immA[7] = 1'b1;
		ram[8'h80] = d0;
		ram[8'h81] = d1;
		ram[8'h82] = d2;

		progPtr = 8'd0;
		emit(movi(4'd14, 8'h80));
		emit(memOp(cpuPkg::funcLoad, 4'd1, 4'd14));
		emit(movi(4'd14, 8'h81));
		emit(memOp(cpuPkg::funcLoad, 4'd2, 4'd14));
		emit(movi(4'd3, immA));
		storeAt(4'd3, 8'ha0);
		expectWord("movi", 8'ha0, {8'h00, immA});
		aluCase("add", cpuPkg::funcAdd, 8'ha1, d0 + d1);
		aluCase("sub", cpuPkg::funcSub, 8'ha2, d0 - d1);
		aluCase("and", cpuPkg::funcAnd, 8'ha3, d0 & d1);
		aluCase("or", cpuPkg::funcOr, 8'ha4, d0 | d1);
		aluCase("xor", cpuPkg::funcXor, 8'ha5, d0 ^ d1);
		aluCase("mov", cpuPkg::funcMov, 8'ha6, d1);

		// Store, load back into other registers and store again
		storeAt(4'd1, 8'hb0);
		expectWord("stor", 8'hb0, d0);
		emit(movi(4'd14, 8'hb0));
		emit(memOp(cpuPkg::funcLoad, 4'd5, 4'd14));
		storeAt(4'd5, 8'hb1);
		expectWord("load stored word", 8'hb1, d0);
		emit(movi(4'd14, 8'h82));
		emit(memOp(cpuPkg::funcLoad, 4'd6, 4'd14));
		storeAt(4'd6, 8'hb2);
		expectWord("load data word", 8'hb2, d2);
		emit(movi(4'd14, 8'ha1));
		emit(memOp(cpuPkg::funcLoad, 4'd7, 4'd14));
		storeAt(4'd7, 8'hb3);
		expectWord("load add result", 8'hb3, d0 + d1);

		emit(movi(4'd9, poison[7:0]));
		emit(movi(4'd10, marker[7:0]));
		// r5 holds d0 again, so Z is set and BEQ skips the poison store
		emit(rType(cpuPkg::funcCmp, 4'd1, 4'd5));
		branchOver(cpuPkg::condEq, 4'd9, 8'hc0);
		expectWord("beq taken", 8'hc0, fillWord(8'hc0));
		emit(rType(cpuPkg::funcCmp, 4'd1, 4'd2));
		branchOver(cpuPkg::condEq, 4'd10, 8'hc1);
		expectWord("beq not taken", 8'hc1, marker);
		// BGT is taken when the destination is unsigned lower than the source
		emit(movi(4'd11, 8'h05));
		emit(movi(4'd12, 8'h40));
		emit(rType(cpuPkg::funcCmp, 4'd11, 4'd12));
		branchOver(cpuPkg::condGt, 4'd9, 8'hc2);
		expectWord("bgt taken", 8'hc2, fillWord(8'hc2));
		emit(rType(cpuPkg::funcCmp, 4'd12, 4'd11));
		branchOver(cpuPkg::condGt, 4'd10, 8'hc3);
		expectWord("bgt not taken", 8'hc3, marker);
		emit(rType(cpuPkg::funcCmp, 4'd1, 4'd2));
		branchOver(cpuPkg::condGt, 4'd10, 8'hc4);
		expectWord("bgt random", 8'hc4, (d0 < d1) ? fillWord(8'hc4) : marker);
		branchOver(cpuPkg::condUn, 4'd9, 8'hc5);
		expectWord("bun skip", 8'hc5, fillWord(8'hc5));
		storeAt(4'd10, 8'hc6);
		expectWord("bun landing", 8'hc6, marker);
		haltPc = {8'h00, progPtr};
		emit(branchOp(cpuPkg::condUn, 8'h00));

		repeat (4) @(posedge clk);
		rst <= 1'b0;
		// One startup cycle, then the first fetch
		@(posedge clk);
		@(negedge clk);
		if (memAddr !== '0) begin
			$display("MISMATCH first fetch: expected %h, actual %h", 16'h0000, memAddr);
			errors++;
		end

		// The halt loop holds one fetch address for good
		lastAddr = memAddr;
		steady = 0;
		cycles = 0;
		while (steady < haltLimit && cycles < maxCycles) begin
			@(negedge clk);
			cycles++;
			if (memAddr == lastAddr) begin
				steady++;
			end else begin
				steady = 0;
			end
			lastAddr = memAddr;
		end
		if (steady < haltLimit) begin
			$display("Timeout: the program did not reach its halt loop in %0d cycles", maxCycles);
			timeouts++;
		end else if (memAddr !== haltPc) begin
			$display("MISMATCH halt address: expected %h, actual %h", haltPc, memAddr);
			errors++;
		end

		for (int i = 0; i < expName.size(); i++) begin
			if (ram[expAddr[i]] !== expVal[i]) begin
				$display("MISMATCH %s: expected %h, actual %h", expName[i], expVal[i],
					ram[expAddr[i]]);
				errors++;
			end
		end

		assertFails = dut0.uFsm.fsmChecks.failCount;
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			errors, timeouts, assertFails);
		if (errors + timeouts + assertFails == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
